// ==== fetch_frontend.f ====
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/fetch_icache.sv
src/fetch_inst_buffer.sv
src/fetch_frontend.sv
sim/fetch_l2_model.sv
sim/fetch_frontend_chk.sv
sim/tb_fetch_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch frontend testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_fetch_frontend -f fetch_frontend.f || exit 1
# assertion errors do not stop the run early, the bench reports them
out=$(./obj_dir/Vtb_fetch_frontend +verilator+error+limit+1000 2>&1)
echo "$out"
echo "$out" | grep -q "All tests passed!" && echo "simulation PASSED" \
  || { echo "simulation FAILED"; exit 1; }

// ==== sim/fetch_frontend_chk.sv ====
`timescale 1ns/1ps

module fetch_frontend_chk (
  input logic              i_clk,
  input logic              i_reset_n,
  input logic              i_redirect_valid,
  input logic              i_disp_valid,
  input logic              i_disp_ready,
  input fetch_pkg::vaddr_t i_disp_pc,
  input fetch_pkg::inst_t  i_disp_inst,
  input logic              i_l2_req,
  input logic              i_l2_ack,
  input fetch_pkg::vaddr_t i_l2_addr
);

  int fail_count = 0;

  // ============================================================
  // dispatch
  // ============================================================

  // stalled entry holds until taken, a redirect may drop it
  a_disp_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid && !i_disp_ready |=>
      i_redirect_valid || (i_disp_valid && $stable(i_disp_pc) && $stable(i_disp_inst)))
    else begin
      fail_count = fail_count + 1;
      $error("dispatch pc or inst changed while stalled");
    end

  // ============================================================
  // L2 four-phase handshake
  // ============================================================

  a_req_rise: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $rose(i_l2_req) |-> !i_l2_ack)
    else begin
      fail_count = fail_count + 1;
      $error("L2 req rose while ack was still high");
    end

  a_addr_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_l2_req |=> !i_l2_req || $stable(i_l2_addr))
    else begin
      fail_count = fail_count + 1;
      $error("L2 address changed while req was high");
    end

  a_req_fall: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $fell(i_l2_req) |-> $past(i_l2_ack))
    else begin
      fail_count = fail_count + 1;
      $error("L2 req fell before ack rose");
    end

endmodule

bind fetch_frontend fetch_frontend_chk u_fetch_frontend_chk (
  .i_clk            (i_clk),
  .i_reset_n        (i_reset_n),
  .i_redirect_valid (i_redirect_valid),
  .i_disp_valid     (o_disp_valid),
  .i_disp_ready     (i_disp_ready),
  .i_disp_pc        (o_disp_pc),
  .i_disp_inst      (o_disp_inst),
  .i_l2_req         (o_l2_req),
  .i_l2_ack         (i_l2_ack),
  .i_l2_addr        (o_l2_addr)
);

// ==== sim/fetch_l2_model.sv ====
`timescale 1ns/1ps

module fetch_l2_model (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_req,
  input  fetch_pkg::vaddr_t i_addr,
  input  logic [7:0]        i_gen,
  output logic              o_ack,
  output fetch_pkg::line_t  o_data
);

  integer seed = 64632;
  int     r_wait;
  int     r_delay;

  // word k holds its own address, generation in the top byte
  function automatic fetch_pkg::line_t line_data(input fetch_pkg::vaddr_t addr,
                                                 input logic [7:0] gen);
    fetch_pkg::line_t line;
    for (int k = 0; k < fetch_pkg::WORDS_PER_LINE; k++) begin
      line[k*fetch_pkg::INST_W +: fetch_pkg::INST_W] =
        (addr + fetch_pkg::vaddr_t'(4 * k)) ^ {gen, 24'h0};
    end
    return line;
  endfunction

  always @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ack   <= 1'b0;
      o_data  <= '0;
      r_wait  <= 0;
      r_delay <= 1 + int'($unsigned($random(seed)) % 6);
    end else if (o_ack) begin
      // ack drops once req is gone, next delay drawn here
      if (!i_req) begin
        o_ack   <= 1'b0;
        r_delay <= 1 + int'($unsigned($random(seed)) % 6);
      end
    end else if (i_req) begin
      if (r_wait + 1 >= r_delay) begin
        o_ack  <= 1'b1;
        o_data <= line_data(i_addr, i_gen);
        r_wait <= 0;
      end else begin
        r_wait <= r_wait + 1;
      end
    end
  end

endmodule

// ==== sim/tb_fetch_frontend.sv ====
`timescale 1ns/1ps

module tb_fetch_frontend;

  localparam int TIMEOUT = 2000;

  logic                      i_clk;
  logic                      i_reset_n;
  logic                      i_redirect_valid;
  fetch_pkg::redirect_kind_t i_redirect_kind;
  fetch_pkg::vaddr_t         i_redirect_pc;
  logic                      i_flush_valid;
  fetch_pkg::vaddr_t         i_mepc;
  fetch_pkg::vaddr_t         i_mtvec;
  logic                      o_l2_req;
  fetch_pkg::vaddr_t         o_l2_addr;
  logic                      i_l2_ack;
  fetch_pkg::line_t          i_l2_data;
  logic                      o_disp_valid;
  fetch_pkg::vaddr_t         o_disp_pc;
  fetch_pkg::inst_t          o_disp_inst;
  logic                      i_disp_ready;
  logic [7:0]                gen;

  integer                    seed = 64632;
  fetch_pkg::vaddr_t         exp_pc;
  fetch_pkg::inst_t          exp_inst;
  int                        n_disp;

  initial i_clk = 1'b0;
  always #4 i_clk = ~i_clk;

  fetch_frontend u_fetch_frontend (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_redirect_valid (i_redirect_valid),
    .i_redirect_kind  (i_redirect_kind),
    .i_redirect_pc    (i_redirect_pc),
    .i_flush_valid    (i_flush_valid),
    .i_mepc           (i_mepc),
    .i_mtvec          (i_mtvec),
    .o_l2_req         (o_l2_req),
    .o_l2_addr        (o_l2_addr),
    .i_l2_ack         (i_l2_ack),
    .i_l2_data        (i_l2_data),
    .o_disp_valid     (o_disp_valid),
    .o_disp_pc        (o_disp_pc),
    .o_disp_inst      (o_disp_inst),
    .i_disp_ready     (i_disp_ready)
  );

  fetch_l2_model u_fetch_l2_model (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_req     (o_l2_req),
    .i_addr    (o_l2_addr),
    .i_gen     (gen),
    .o_ack     (i_l2_ack),
    .o_data    (i_l2_data)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  // ============================================================
  // scoreboard
  // ============================================================

  // sampled at negedge so a transfer seen here lands on the next rising edge
  always @(negedge i_clk) begin
    if (u_fetch_frontend.u_fetch_frontend_chk.fail_count != 0) begin
      abort_run("a bound assertion on dispatch or the L2 handshake failed");
    end
    if (!i_reset_n) begin
      exp_pc = fetch_pkg::PC_RESET;
      n_disp = 0;
    end else if (i_redirect_valid) begin
      case (i_redirect_kind)
        fetch_pkg::REDIR_MRET:  exp_pc = i_mepc;
        fetch_pkg::REDIR_ECALL: exp_pc = i_mtvec;
        default:                exp_pc = i_redirect_pc;
      endcase
    end else if (o_disp_valid && i_disp_ready) begin
      exp_inst = exp_pc ^ {gen, 24'h0};
      a_disp_pc: assert (o_disp_pc == exp_pc) else begin
        $display("Mismatch at time %0t: o_disp_pc got %h expected %h",
                 $time, o_disp_pc, exp_pc);
        $display("Test failures found");
        $fatal(1);
      end
      a_disp_inst: assert (o_disp_inst == exp_inst) else begin
        $display("Mismatch at time %0t: o_disp_inst got %h expected %h",
                 $time, o_disp_inst, exp_inst);
        $display("Test failures found");
        $fatal(1);
      end
      exp_pc = exp_pc + 32'd4;
      n_disp = n_disp + 1;
    end
  end

  // ============================================================
  // stimulus helpers
  // ============================================================

  // a flush also moves memory to the next generation
  task automatic send_redirect(input fetch_pkg::redirect_kind_t kind,
                               input fetch_pkg::vaddr_t pc, input logic flush);
    @(posedge i_clk);
    i_redirect_valid <= 1'b1;
    i_redirect_kind  <= kind;
    i_redirect_pc    <= pc;
    i_flush_valid    <= flush;
    if (flush) begin
      gen <= gen + 8'd1;
    end
    @(posedge i_clk);
    i_redirect_valid <= 1'b0;
    i_flush_valid    <= 1'b0;
  endtask

  task automatic wait_disp(input int count);
    int target;
    int cycles;
    target = n_disp + count;
    cycles = 0;
    while (n_disp < target) begin
      @(posedge i_clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timed out waiting for dispatched instructions");
      end
    end
  endtask

  // ready low about half the time
  task automatic stall_randomly(input int count);
    int target;
    int cycles;
    target = n_disp + count;
    cycles = 0;
    while (n_disp < target) begin
      @(posedge i_clk);
      i_disp_ready <= ($random(seed) & 1) != 0;
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timed out dispatching under random stalls");
      end
    end
    @(posedge i_clk);
    i_disp_ready <= 1'b1;
  endtask

  task automatic wait_l2(input logic want_busy);
    int cycles;
    cycles = 0;
    @(negedge i_clk);
    while ((o_l2_req | i_l2_ack) != want_busy) begin
      @(negedge i_clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timed out waiting on the L2 port");
      end
    end
  endtask

  // ============================================================
  // test sequence
  // ============================================================

  initial begin
    i_reset_n        = 1'b0;
    i_redirect_valid = 1'b0;
    i_redirect_kind  = fetch_pkg::REDIR_BRANCH;
    i_redirect_pc    = '0;
    i_flush_valid    = 1'b0;
    i_mepc           = 32'h0000_1204;
    i_mtvec          = 32'h0000_1300;
    i_disp_ready     = 1'b0;
    gen              = 8'h00;
    repeat (10) @(posedge i_clk);
    i_reset_n    <= 1'b1;
    i_disp_ready <= 1'b1;

    // cold pass over eight lines and a second pass from the cache
    wait_disp(32);
    send_redirect(fetch_pkg::REDIR_BRANCH, 32'h0000_1000, 1'b0);
    wait_disp(32);

    // stale lines still cached must refetch with the new generation
    send_redirect(fetch_pkg::REDIR_BRANCH, 32'h0000_1000, 1'b1);
    wait_disp(40);

    // mid-line branch and the two trap kinds
    send_redirect(fetch_pkg::REDIR_BRANCH, 32'h0000_1108, 1'b0);
    wait_disp(10);
    send_redirect(fetch_pkg::REDIR_MRET, 32'h0, 1'b0);
    wait_disp(6);
    send_redirect(fetch_pkg::REDIR_ECALL, 32'h0, 1'b0);
    wait_disp(6);

    // back-pressure over fresh lines
    send_redirect(fetch_pkg::REDIR_BRANCH, 32'h0000_2000, 1'b0);
    stall_randomly(64);

    // redirect while a refill is outstanding
    for (int i = 0; i < 3; i++) begin
      send_redirect(fetch_pkg::REDIR_BRANCH, fetch_pkg::vaddr_t'(32'h3000 + 256 * i), 1'b0);
      wait_l2(1'b1);
      send_redirect(fetch_pkg::REDIR_BRANCH, fetch_pkg::vaddr_t'(32'h4008 + 64 * i), 1'b0);
      wait_disp(6);
    end
    wait_l2(1'b0);
    repeat (20) @(posedge i_clk);

    if (u_fetch_frontend.u_fetch_frontend_chk.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1);
    end
  end

endmodule

// ==== src/fetch_frontend.sv ====
`timescale 1ns/1ps

module fetch_frontend (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  // committer
  input  logic                      i_redirect_valid,
  input  fetch_pkg::redirect_kind_t i_redirect_kind,
  input  fetch_pkg::vaddr_t         i_redirect_pc,
  input  logic                      i_flush_valid,
  input  fetch_pkg::vaddr_t         i_mepc,
  input  fetch_pkg::vaddr_t         i_mtvec,
  // L2 refill
  output logic                      o_l2_req,
  output fetch_pkg::vaddr_t         o_l2_addr,
  input  logic                      i_l2_ack,
  input  fetch_pkg::line_t          i_l2_data,
  // dispatch
  output logic                      o_disp_valid,
  output fetch_pkg::vaddr_t         o_disp_pc,
  output fetch_pkg::inst_t          o_disp_inst,
  input  logic                      i_disp_ready
);

  logic              w_kill;
  logic              w_req_valid;
  fetch_pkg::vaddr_t w_req_addr;
  logic              w_ic_ready;
  logic              w_resp_valid;
  fetch_pkg::vaddr_t w_resp_addr;
  fetch_pkg::line_t  w_resp_line;
  logic              w_miss_valid;
  fetch_pkg::vaddr_t w_miss_addr;
  logic              w_credit;

  fetch_pc_gen u_fetch_pc_gen (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_redirect_valid (i_redirect_valid),
    .i_redirect_kind  (i_redirect_kind),
    .i_redirect_pc    (i_redirect_pc),
    .i_mepc           (i_mepc),
    .i_mtvec          (i_mtvec),
    .i_ic_ready       (w_ic_ready),
    .i_miss_valid     (w_miss_valid),
    .i_miss_addr      (w_miss_addr),
    .i_credit         (w_credit),
    .o_kill           (w_kill),
    .o_req_valid      (w_req_valid),
    .o_req_addr       (w_req_addr)
  );

  fetch_icache u_fetch_icache (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_kill       (w_kill),
    .i_flush      (i_flush_valid),
    .i_req_valid  (w_req_valid),
    .i_req_addr   (w_req_addr),
    .i_l2_ack     (i_l2_ack),
    .i_l2_data    (i_l2_data),
    .o_ready      (w_ic_ready),
    .o_resp_valid (w_resp_valid),
    .o_resp_addr  (w_resp_addr),
    .o_resp_line  (w_resp_line),
    .o_miss_valid (w_miss_valid),
    .o_miss_addr  (w_miss_addr),
    .o_l2_req     (o_l2_req),
    .o_l2_addr    (o_l2_addr)
  );

  // pc_gen only raises valid when the cache accepts
  fetch_inst_buffer u_fetch_inst_buffer (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_kill       (w_kill),
    .i_issue      (w_req_valid),
    .i_line_valid (w_resp_valid),
    .i_line_addr  (w_resp_addr),
    .i_line       (w_resp_line),
    .i_disp_ready (i_disp_ready),
    .o_credit     (w_credit),
    .o_disp_valid (o_disp_valid),
    .o_disp_pc    (o_disp_pc),
    .o_disp_inst  (o_disp_inst)
  );

endmodule

// ==== src/fetch_icache.sv ====
`timescale 1ns/1ps

module fetch_icache (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_kill,
  input  logic              i_flush,
  input  logic              i_req_valid,
  input  fetch_pkg::vaddr_t i_req_addr,
  input  logic              i_l2_ack,
  input  fetch_pkg::line_t  i_l2_data,
  output logic              o_ready,
  output logic              o_resp_valid,
  output fetch_pkg::vaddr_t o_resp_addr,
  output fetch_pkg::line_t  o_resp_line,
  output logic              o_miss_valid,
  output fetch_pkg::vaddr_t o_miss_addr,
  output logic              o_l2_req,
  output fetch_pkg::vaddr_t o_l2_addr
);

  fetch_pkg::ic_tag_t            r_tag_mem  [fetch_pkg::IC_SETS];
  fetch_pkg::line_t              r_data_mem [fetch_pkg::IC_SETS];
  logic [fetch_pkg::IC_SETS-1:0] r_valid_bits;

  fetch_pkg::refill_state_t      r_rf_state;
  fetch_pkg::vaddr_t             r_l2_addr;
  fetch_pkg::ic_index_t          w_rf_index;
  logic                          w_rf_fill;
  logic                          w_flush;

  logic                          w_s0_fire;
  logic                          r_s1_valid;
  fetch_pkg::vaddr_t             r_s1_addr;
  fetch_pkg::ic_index_t          w_s1_index;
  logic                          r_s2_valid;
  fetch_pkg::vaddr_t             r_s2_addr;
  fetch_pkg::ic_tag_t            r_s2_tag;
  logic                          r_s2_line_vld;
  fetch_pkg::line_t              r_s2_line;
  logic                          w_s2_hit;
  logic                          w_s2_miss;

  // flush only counts alongside a redirect
  assign w_flush = i_flush & i_kill;

  // ============================================================
  // s0 request / s1 array read
  // ============================================================

  // hold off while refilling or while the last ack is still high
  assign o_ready    = (r_rf_state == fetch_pkg::RF_IDLE) & ~i_l2_ack;
  assign w_s0_fire  = i_req_valid & o_ready & ~i_kill & ~w_s2_miss;
  assign w_s1_index = r_s1_addr[fetch_pkg::LINE_OFF_W +: fetch_pkg::IC_IDX_W];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
    end else begin
      r_s1_valid <= w_s0_fire;
      // a miss kills the younger s1 request
      r_s2_valid <= r_s1_valid & ~i_kill & ~w_s2_miss;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_addr     <= i_req_addr;
    r_s2_addr     <= r_s1_addr;
    r_s2_tag      <= r_tag_mem[w_s1_index];
    r_s2_line     <= r_data_mem[w_s1_index];
    r_s2_line_vld <= r_valid_bits[w_s1_index];
  end

  // ============================================================
  // s2 compare and response
  // ============================================================

  assign w_s2_hit = r_s2_line_vld &
                    (r_s2_tag == r_s2_addr[fetch_pkg::VADDR_W-1 -: fetch_pkg::IC_TAG_W]);
  assign w_s2_miss = r_s2_valid & ~w_s2_hit & ~i_kill;

  assign o_resp_valid = r_s2_valid & w_s2_hit & ~i_kill;
  assign o_resp_addr  = r_s2_addr;
  assign o_resp_line  = r_s2_line;
  assign o_miss_valid = w_s2_miss;
  assign o_miss_addr  = r_s2_addr;

  // ============================================================
  // refill from L2, four-phase req/ack
  // ============================================================

  assign w_rf_index = r_l2_addr[fetch_pkg::LINE_OFF_W +: fetch_pkg::IC_IDX_W];
  assign w_rf_fill  = (r_rf_state == fetch_pkg::RF_REQ) & i_l2_ack & ~i_kill;
  assign o_l2_req   = (r_rf_state == fetch_pkg::RF_REQ) | (r_rf_state == fetch_pkg::RF_DROP);
  assign o_l2_addr  = r_l2_addr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rf_state <= fetch_pkg::RF_IDLE;
      r_l2_addr  <= '0;
    end else begin
      case (r_rf_state)
        fetch_pkg::RF_IDLE: begin
          if (w_s2_miss) begin
            r_rf_state <= fetch_pkg::RF_REQ;
            r_l2_addr  <= {r_s2_addr[fetch_pkg::VADDR_W-1:fetch_pkg::LINE_OFF_W],
                           {fetch_pkg::LINE_OFF_W{1'b0}}};
          end
        end
        fetch_pkg::RF_REQ: begin
          // data taken on ack, req drops next cycle
          if (i_l2_ack) begin
            r_rf_state <= fetch_pkg::RF_IDLE;
          end else if (i_kill) begin
            r_rf_state <= fetch_pkg::RF_DROP;
          end
        end
        fetch_pkg::RF_DROP: begin
          if (i_l2_ack) begin
            r_rf_state <= fetch_pkg::RF_IDLE;
          end
        end
        default: r_rf_state <= fetch_pkg::RF_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_rf_fill) begin
      r_tag_mem[w_rf_index]  <= r_l2_addr[fetch_pkg::VADDR_W-1 -: fetch_pkg::IC_TAG_W];
      r_data_mem[w_rf_index] <= i_l2_data;
    end
  end

  // flush wins over a fill in the same cycle
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid_bits <= '0;
    end else if (w_flush) begin
      r_valid_bits <= '0;
    end else if (w_rf_fill) begin
      r_valid_bits[w_rf_index] <= 1'b1;
    end
  end

endmodule

// ==== src/fetch_inst_buffer.sv ====
`timescale 1ns/1ps

module fetch_inst_buffer (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_kill,
  input  logic              i_issue,
  input  logic              i_line_valid,
  input  fetch_pkg::vaddr_t i_line_addr,
  input  fetch_pkg::line_t  i_line,
  input  logic              i_disp_ready,
  output logic              o_credit,
  output logic              o_disp_valid,
  output fetch_pkg::vaddr_t o_disp_pc,
  output fetch_pkg::inst_t  o_disp_inst
);

  fetch_pkg::line_t r_ent_line [fetch_pkg::IB_DEPTH];
  logic [fetch_pkg::VADDR_W-fetch_pkg::LINE_OFF_W-1:0] r_ent_base [fetch_pkg::IB_DEPTH];
  logic [fetch_pkg::WORD_OFF_W-1:0] r_ent_slot [fetch_pkg::IB_DEPTH];

  logic [fetch_pkg::IB_PTR_W-1:0]   r_head;
  logic [fetch_pkg::IB_PTR_W-1:0]   r_tail;
  logic [fetch_pkg::IB_PTR_W:0]     r_count;
  logic [fetch_pkg::IB_PTR_W:0]     w_free;
  logic                             r_if1;
  logic                             r_if2;
  logic [1:0]                       w_inflight;
  logic [fetch_pkg::WORD_OFF_W-1:0] w_head_slot;
  logic                             w_last_word;
  logic                             w_disp_fire;
  logic                             w_push;
  logic                             w_pop;

  // ============================================================
  // dispatch side
  // ============================================================

  assign w_head_slot  = r_ent_slot[r_head];
  assign w_last_word  = (w_head_slot == {fetch_pkg::WORD_OFF_W{1'b1}});
  assign o_disp_valid = (r_count != '0) & ~i_kill;
  assign o_disp_pc    = {r_ent_base[r_head], w_head_slot,
                         {(fetch_pkg::LINE_OFF_W - fetch_pkg::WORD_OFF_W){1'b0}}};
  assign o_disp_inst  = r_ent_line[r_head][w_head_slot*fetch_pkg::INST_W +: fetch_pkg::INST_W];
  assign w_disp_fire  = o_disp_valid & i_disp_ready;

  assign w_push = i_line_valid & ~i_kill;
  assign w_pop  = w_disp_fire & w_last_word;

  // room for one more issue beyond what is already in flight
  assign w_free     = (fetch_pkg::IB_PTR_W+1)'(fetch_pkg::IB_DEPTH) - r_count;
  assign w_inflight = {1'b0, r_if1} + {1'b0, r_if2};
  assign o_credit   = w_free > {1'b0, w_inflight};

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
      r_if1   <= 1'b0;
      r_if2   <= 1'b0;
      for (int i = 0; i < fetch_pkg::IB_DEPTH; i++) begin
        r_ent_slot[i] <= '0;
      end
    end else if (i_kill) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
      r_if1   <= 1'b0;
      r_if2   <= 1'b0;
    end else begin
      // mirror of the s1/s2 stages
      r_if1 <= i_issue;
      r_if2 <= r_if1;
      if (w_disp_fire && !w_last_word) begin
        r_ent_slot[r_head] <= w_head_slot + 1'b1;
      end
      if (w_push) begin
        // first line after a redirect may start mid-line
        r_ent_slot[r_tail] <= i_line_addr[fetch_pkg::LINE_OFF_W-1 -: fetch_pkg::WORD_OFF_W];
        r_tail             <= r_tail + 1'b1;
      end
      if (w_pop) begin
        r_head <= r_head + 1'b1;
      end
      case ({w_push, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_ent_line[r_tail] <= i_line;
      r_ent_base[r_tail] <= i_line_addr[fetch_pkg::VADDR_W-1:fetch_pkg::LINE_OFF_W];
    end
  end

endmodule

// ==== src/fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_redirect_valid,
  input  fetch_pkg::redirect_kind_t i_redirect_kind,
  input  fetch_pkg::vaddr_t         i_redirect_pc,
  input  fetch_pkg::vaddr_t         i_mepc,
  input  fetch_pkg::vaddr_t         i_mtvec,
  input  logic                      i_ic_ready,
  input  logic                      i_miss_valid,
  input  fetch_pkg::vaddr_t         i_miss_addr,
  input  logic                      i_credit,
  output logic                      o_kill,
  output logic                      o_req_valid,
  output fetch_pkg::vaddr_t         o_req_addr
);

  fetch_pkg::vaddr_t r_pc;
  fetch_pkg::vaddr_t w_target;
  fetch_pkg::vaddr_t w_next_line;

  // redirect target by kind
  always_comb begin
    case (i_redirect_kind)
      fetch_pkg::REDIR_MRET:  w_target = i_mepc;
      fetch_pkg::REDIR_ECALL: w_target = i_mtvec;
      default:                w_target = i_redirect_pc;
    endcase
  end

  // next line boundary, drops any mid-line offset
  assign w_next_line = {r_pc[fetch_pkg::VADDR_W-1:fetch_pkg::LINE_OFF_W],
                        {fetch_pkg::LINE_OFF_W{1'b0}}} +
                       fetch_pkg::vaddr_t'(fetch_pkg::LINE_BYTES);

  // no issue in a cycle that reloads the address
  assign o_req_valid = i_ic_ready & i_credit & ~i_redirect_valid & ~i_miss_valid;
  assign o_req_addr  = r_pc;
  assign o_kill      = i_redirect_valid;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_pc <= fetch_pkg::PC_RESET;
    end else begin
      if (i_redirect_valid) begin
        r_pc <= w_target;
      end else if (i_miss_valid) begin
        // replay the missed address once the refill is done
        r_pc <= i_miss_addr;
      end else if (o_req_valid) begin
        r_pc <= w_next_line;
      end
    end
  end

endmodule

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

  // ============================================================
  // widths
  // ============================================================

  localparam int VADDR_W        = 32;
  localparam int LINE_BYTES     = 16;
  localparam int LINE_W         = LINE_BYTES * 8;
  localparam int INST_W         = 32;
  localparam int WORDS_PER_LINE = LINE_W / INST_W;
  localparam int WORD_OFF_W     = $clog2(WORDS_PER_LINE);
  localparam int LINE_OFF_W     = $clog2(LINE_BYTES);

  // ============================================================
  // cache and buffer geometry
  // ============================================================

  localparam int IC_SETS  = 16;
  localparam int IC_IDX_W = $clog2(IC_SETS);
  localparam int IC_TAG_W = VADDR_W - IC_IDX_W - LINE_OFF_W;

  localparam int IB_DEPTH = 4;
  localparam int IB_PTR_W = $clog2(IB_DEPTH);

  typedef logic [VADDR_W-1:0]  vaddr_t;
  typedef logic [LINE_W-1:0]   line_t;
  typedef logic [INST_W-1:0]   inst_t;
  typedef logic [IC_IDX_W-1:0] ic_index_t;
  typedef logic [IC_TAG_W-1:0] ic_tag_t;

  // first fetch address out of reset
  localparam vaddr_t PC_RESET = 32'h0000_1000;

  typedef enum logic [1:0] {
    REDIR_BRANCH,
    REDIR_MRET,
    REDIR_ECALL
  } redirect_kind_t;

  // refill FSM, RF_DROP finishes a killed handshake
  typedef enum logic [1:0] {
    RF_IDLE,
    RF_REQ,
    RF_DROP
  } refill_state_t;

endpackage
